// File: logic/lsu_pkg.sv
// Load/store unit shared widths, access size encoding and payload structs
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  parameter int unsigned XLEN = 32;
  // Byte lanes per data word
  parameter int unsigned BE_W = XLEN / 8;

  //////////////////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  //////////////////////////////////////////////////////////////////////
  // Payloads
  //////////////////////////////////////////////////////////////////////

  // Request from the execute stage
  typedef struct packed {
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    // Address is op_a + op_b when set, else op_a
    logic            use_incr;
    logic            we;
    lsu_size_e       size;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  // Data bus request
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  // Per-transaction control kept until the response
  typedef struct packed {
    logic [1:0] offset;
    lsu_size_e  size;
    logic       sign_ext;
    logic       we;
  } lsu_ctrl_t;

  // Response toward write-back
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
    logic            we;
  } lsu_rsp_t;

endpackage

// File: logic/lsu_issue.sv
// Load/store issue stage: address, byte enables, store lane rotation and bus handshake
`timescale 1ns/1ps

module lsu_issue (
  // Execute side
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              req_ready_o,

  // Free entry in the transaction tracker
  input  logic              slot_free_i,

  // Bus request side
  output logic              bus_valid_o,
  output lsu_pkg::bus_req_t bus_req_o,
  input  logic              bus_gnt_i,

  // Control record toward the tracker
  output logic               push_o,
  output lsu_pkg::lsu_ctrl_t push_ctrl_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] addr;
  logic [1:0]      offset;
  logic [BE_W-1:0] be;
  logic [XLEN-1:0] wdata_rot;

  //////////////////////////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////////////////////////

  // Optional add of the second operand
  assign addr   = req_i.use_incr ? (req_i.op_a + req_i.op_b) : req_i.op_a;
  // Byte position inside the word
  assign offset = addr[1:0];

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      SIZE_BYTE:
      begin
        // Single lane at the offset
        case (offset)
          2'b00: be = 4'b0001;
          2'b01: be = 4'b0010;
          2'b10: be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
      SIZE_HALF:
      begin
        // Two adjacent lanes; offset 3 would cross the word
        case (offset)
          2'b00: be = 4'b0011;
          2'b01: be = 4'b0110;
          2'b10: be = 4'b1100;
          default: be = 4'b1000;
        endcase
      end
      default:
      begin
        // Full word, always aligned
        be = 4'b1111;
      end
    endcase
  end

  // Rotate left by the offset so operand byte 0 lands on the addressed lane
  always_comb
  begin
    case (offset)
      2'b00: wdata_rot = req_i.wdata;
      2'b01: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Bus handshake
  //////////////////////////////////////////////////////////////////////

  // Request goes out only while the tracker has room
  assign bus_valid_o = req_valid_i && slot_free_i;

  assign bus_req_o.addr  = addr;
  assign bus_req_o.we    = req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  // Grant completes the request phase toward execute
  assign req_ready_o = bus_valid_o && bus_gnt_i;

  // Control record saved on every accepted access
  assign push_o               = req_ready_o;
  assign push_ctrl_o.offset   = offset;
  assign push_ctrl_o.size     = req_i.size;
  assign push_ctrl_o.sign_ext = req_i.sign_ext;
  assign push_ctrl_o.we       = req_i.we;

endmodule

// File: logic/lsu_txn_tracker.sv
// Outstanding transaction counter with an in-order queue of control records
`timescale 1ns/1ps

module lsu_txn_tracker #(
  parameter int unsigned DEPTH = 2
) (
  input  logic               clk,
  input  logic               rst_n,

  // Accepted access
  input  logic               push_i,
  input  lsu_pkg::lsu_ctrl_t push_ctrl_i,

  // Response received
  input  logic               pop_i,

  output logic               slot_free_o,
  output lsu_pkg::lsu_ctrl_t head_ctrl_o,
  output logic               busy_o
);

  import lsu_pkg::*;

  // Count must hold the value DEPTH itself
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  // At least one pointer bit even for a single entry
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;

  // Control record storage
  lsu_ctrl_t ctrl_mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Outstanding count
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({push_i, pop_i})
      2'b10: cnt_d = cnt_q + 1'b1;
      2'b01: cnt_d = cnt_q - 1'b1;
      // Push with pop, or idle
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
    end
  end

  // Credit limit for new accesses
  assign slot_free_o = (cnt_q < CNT_W'(DEPTH));
  assign busy_o      = (cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Control queue
  //////////////////////////////////////////////////////////////////////

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push_i)
      begin
        if (wr_ptr_q == PTR_W'(DEPTH - 1))
          wr_ptr_q <= '0;
        else
          wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i)
      begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1))
          rd_ptr_q <= '0;
        else
          rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Payload storage, written at the write pointer
  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      ctrl_mem[wr_ptr_q] <= push_ctrl_i;
    end
  end

  // Oldest record belongs to the next response
  assign head_ctrl_o = ctrl_mem[rd_ptr_q];

endmodule

// File: logic/lsu_rdata_align.sv
// Load data extraction and zero or sign extension on the response path
`timescale 1ns/1ps

module lsu_rdata_align (
  // Bus response
  input  logic                     bus_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata_i,
  input  logic                     bus_err_i,

  // Control of the oldest outstanding access
  input  lsu_pkg::lsu_ctrl_t       head_ctrl_i,

  // Write-back side
  output logic                     rsp_valid_o,
  output lsu_pkg::lsu_rsp_t        rsp_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] rdata_shift;
  logic            ext_bit;
  logic [XLEN-1:0] rdata_ext;

  //////////////////////////////////////////////////////////////////////
  // Lane extraction
  //////////////////////////////////////////////////////////////////////

  // Addressed byte moves down to lane 0
  assign rdata_shift = bus_rdata_i >> {head_ctrl_i.offset, 3'b000};

  always_comb
  begin
    ext_bit   = 1'b0;
    rdata_ext = bus_rdata_i;
    case (head_ctrl_i.size)
      SIZE_BYTE:
      begin
        // Top bit of the selected byte when signed
        ext_bit   = head_ctrl_i.sign_ext & rdata_shift[7];
        rdata_ext = {{(XLEN - 8){ext_bit}}, rdata_shift[7:0]};
      end
      SIZE_HALF:
      begin
        ext_bit   = head_ctrl_i.sign_ext & rdata_shift[15];
        rdata_ext = {{(XLEN - 16){ext_bit}}, rdata_shift[15:0]};
      end
      default:
      begin
        // Word passes through unchanged
        rdata_ext = bus_rdata_i;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  // Same cycle as rvalid, no back-pressure from write-back
  assign rsp_valid_o = bus_rvalid_i;

  // Store responses carry the same extraction, ignored downstream
  assign rsp_o.rdata = rdata_ext;
  assign rsp_o.err   = bus_err_i;
  assign rsp_o.we    = head_ctrl_i.we;

endmodule

// File: logic/lsu_top.sv
// Load/store unit top level joining issue, transaction tracking and load alignment
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // Execute side
  input  logic                     req_valid_i,
  input  lsu_pkg::lsu_req_t        req_i,
  output logic                     req_ready_o,

  // Data bus
  output logic                     bus_valid_o,
  output lsu_pkg::bus_req_t        bus_req_o,
  input  logic                     bus_gnt_i,
  input  logic                     bus_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata_i,
  input  logic                     bus_err_i,

  // Write-back side
  output logic                     rsp_valid_o,
  output lsu_pkg::lsu_rsp_t        rsp_o,
  output logic                     busy_o
);

  import lsu_pkg::*;

  // Issue to tracker
  logic      push;
  lsu_ctrl_t push_ctrl;
  logic      slot_free;

  // Tracker to alignment
  lsu_ctrl_t head_ctrl;

  lsu_issue u_issue (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .slot_free_i (slot_free),
    .bus_valid_o (bus_valid_o),
    .bus_req_o   (bus_req_o),
    .bus_gnt_i   (bus_gnt_i),
    .push_o      (push),
    .push_ctrl_o (push_ctrl)
  );

  // Each rvalid retires the oldest access
  lsu_txn_tracker #(
    .DEPTH (DEPTH)
  ) u_txn_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_ctrl_i (push_ctrl),
    .pop_i       (bus_rvalid_i),
    .slot_free_o (slot_free),
    .head_ctrl_o (head_ctrl),
    .busy_o      (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_err_i    (bus_err_i),
    .head_ctrl_i  (head_ctrl),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

// File: test/lsu_sva.sv
// Load/store unit checks on bus request hold, word boundary and outstanding limit
`timescale 1ns/1ps

module lsu_sva #(
  parameter int unsigned DEPTH = 2
) (
  input logic              clk,
  input logic              rst_n,
  input lsu_pkg::lsu_req_t req_i,
  input logic              bus_valid_i,
  input lsu_pkg::bus_req_t bus_req_i,
  input logic              bus_gnt_i,
  input logic              bus_rvalid_i
);

  import lsu_pkg::*;

  // Accepted accesses still waiting for rvalid
  int unsigned outstanding;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= 0;
    else
      outstanding <= outstanding + (bus_valid_i && bus_gnt_i) - bus_rvalid_i;
  end

  // Valid and payload hold until the grant
  a_hold_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    bus_valid_i && !bus_gnt_i |=> bus_valid_i && $stable(bus_req_i))
  else $error("bus request dropped or changed before grant");

  // Halfword at offset 3 or unaligned word would spill into the next word
  a_in_one_word: assert property (@(posedge clk) disable iff (!rst_n)
    bus_valid_i && bus_gnt_i |->
      !((req_i.size == SIZE_HALF && bus_req_i.addr[1:0] == 2'b11) ||
        (req_i.size == SIZE_WORD && bus_req_i.addr[1:0] != 2'b00)))
  else $error("accepted access crosses a word boundary");

  a_outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= DEPTH)
  else $error("more than DEPTH accesses outstanding");

endmodule

bind lsu_top lsu_sva #(
  .DEPTH (DEPTH)
) u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .req_i        (req_i),
  .bus_valid_i  (bus_valid_o),
  .bus_req_i    (bus_req_o),
  .bus_gnt_i    (bus_gnt_i),
  .bus_rvalid_i (bus_rvalid_i)
);

// File: test/lsu_tb.sv
// Load/store unit testbench with random traffic, a bus memory model and a response scoreboard
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int DEPTH      = 2;
  localparam int NUM_TXN    = 400;
  // Up to 12 cycles per access, plus reset and drain
  localparam int MAX_CYCLES = NUM_TXN * 12 + 200;

  // Expected bus request and response of one access
  typedef struct packed {
    bus_req_t bus;
    lsu_rsp_t rsp;
  } expect_t;

  // Response queued in the bus model
  typedef struct {
    logic [31:0] rdata;
    logic        err;
    int          due;
  } bus_rsp_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  lsu_req_t    req;
  logic        req_ready;
  logic        bus_valid;
  bus_req_t    bus_req;
  logic        bus_gnt;
  logic        bus_rvalid;
  logic [31:0] bus_rdata;
  logic        bus_err;
  logic        rsp_valid;
  lsu_rsp_t    rsp;
  logic        busy;

  logic [31:0] mem [16];
  logic [31:0] shadow [16];
  lsu_rsp_t    exp_q [$];
  bus_rsp_t    rsp_q [$];
  logic [31:0] rng = 32'h5667;
  logic        seen_accept = 1'b0;
  int          cycle_cnt = 0;
  int          last_due = 0;
  int          issued = 0;
  int          acc_cnt = 0;
  int          rsp_cnt = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;

  lsu_top #(
    .DEPTH (DEPTH)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .bus_valid_o  (bus_valid),
    .bus_req_o    (bus_req),
    .bus_gnt_i    (bus_gnt),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .bus_err_i    (bus_err),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .busy_o       (busy)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_cnt++;
    if (got !== expected)
    begin
      err_cnt++;
      $display("** Error %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, expected,
               cycle_cnt);
    end
  endtask

  // Random access kept inside one aligned word of the 16-word model
  function automatic lsu_req_t make_request(input logic [31:0] r0, input logic [31:0] r1,
                                            input logic [31:0] r2);
    lsu_req_t    r;
    logic [1:0]  off;
    logic [31:0] addr;
    r.size = (r0[1:0] == 2'd0) ? SIZE_BYTE : (r0[1:0] == 2'd1) ? SIZE_HALF : SIZE_WORD;
    off    = r0[7:6];
    if (r.size == SIZE_WORD)
      off = 2'd0;
    else if (r.size == SIZE_HALF && off == 2'd3)
      off = 2'd2;
    addr       = {26'd0, r0[5:2], off};
    r.use_incr = r0[8];
    r.we       = r0[9];
    r.sign_ext = r0[10];
    // op_b is noise unless the add is selected
    r.op_b     = r1;
    r.op_a     = r0[8] ? (addr - r1) : addr;
    r.wdata    = r2;
    return r;
  endfunction

  // Reference model of bus request and response, load data from the shadow memory
  function automatic expect_t predict(input lsu_req_t r);
    expect_t     e;
    logic [31:0] word;
    int          off;
    int          nb;
    int          i;
    e          = '0;
    e.bus.addr = r.use_incr ? (r.op_a + r.op_b) : r.op_a;
    e.bus.we   = r.we;
    off        = e.bus.addr[1:0];
    nb         = (r.size == SIZE_BYTE) ? 1 : (r.size == SIZE_HALF) ? 2 : 4;
    word       = shadow[e.bus.addr[5:2]];
    for (i = 0; i < 4; i++)
    begin
      // Operand byte i goes to lane off + i, wrapping
      e.bus.wdata[8 * ((i + off) % 4) +: 8] = r.wdata[8 * i +: 8];
      e.bus.be[i] = (i >= off) && (i < off + nb);
      if (i < nb)
        e.rsp.rdata[8 * i +: 8] = word[8 * (off + i) +: 8];
    end
    if (r.sign_ext && nb < 4)
      for (i = 8 * nb; i < 32; i++)
        e.rsp.rdata[i] = e.rsp.rdata[8 * nb - 1];
    e.rsp.err = (e.bus.addr[5:2] == 4'd15);
    e.rsp.we  = r.we;
    return e;
  endfunction

  // Memory model at grant: write lanes, capture word, schedule in-order response
  task automatic serve_grant();
    bus_rsp_t r;
    int       idx;
    int       lane;
    idx = bus_req.addr[5:2];
    if (bus_req.we)
      for (lane = 0; lane < 4; lane++)
        if (bus_req.be[lane])
          mem[idx][8 * lane +: 8] = bus_req.wdata[8 * lane +: 8];
    rng     = next_random(rng);
    r.due   = cycle_cnt + 1 + int'(rng % 3);
    if (r.due <= last_due)
      r.due = last_due + 1;
    last_due = r.due;
    r.rdata = mem[idx];
    r.err   = (idx == 15);
    rsp_q.push_back(r);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and bus driver
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [31:0] r0;
    logic [31:0] r1;
    cycle_cnt = cycle_cnt + 1;
    if (rst_n)
    begin
      // New request only once the previous one was taken
      if (!req_valid || seen_accept)
      begin
        rng = next_random(rng);
        r0  = rng;
        rng = next_random(rng);
        r1  = rng;
        rng = next_random(rng);
        if (issued < NUM_TXN && r0[12:11] != 2'd0)
        begin
          req       <= make_request(r0, r1, rng);
          req_valid <= 1'b1;
          issued++;
        end
        else
          req_valid <= 1'b0;
      end
      rng = next_random(rng);
      bus_gnt <= (rng[1:0] != 2'd0);
      if (rsp_q.size() != 0 && rsp_q[0].due <= cycle_cnt)
      begin
        bus_rvalid <= 1'b1;
        bus_rdata  <= rsp_q[0].rdata;
        bus_err    <= rsp_q[0].err;
        rsp_q.delete(0);
      end
      else
      begin
        bus_rvalid <= 1'b0;
        bus_err    <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor and comparison, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    expect_t  exp_val;
    lsu_rsp_t exp_rsp;
    logic     exp_valid;
    int       pend;
    int       lane;
    if (!rst_n)
    begin
      seen_accept = 1'b0;
      check_value("bus_valid_o", bus_valid, 1'b0);
      check_value("req_ready_o", req_ready, 1'b0);
      check_value("rsp_valid_o", rsp_valid, 1'b0);
      check_value("busy_o", busy, 1'b0);
    end
    else
    begin
      pend = acc_cnt - rsp_cnt;
      if (pend > DEPTH)
      begin
        err_cnt++;
        $display("More than %0d accesses outstanding at cycle %0d", DEPTH, cycle_cnt);
      end
      // Request reaches the bus only while fewer than DEPTH accesses wait
      exp_valid = req_valid && (pend < DEPTH);
      check_value("bus_valid_o", bus_valid, exp_valid);
      check_value("req_ready_o", req_ready, exp_valid && bus_gnt);
      check_value("busy_o", busy, pend != 0);
      check_value("rsp_valid_o", rsp_valid, bus_rvalid);
      if (rsp_valid && exp_q.size() == 0)
      begin
        err_cnt++;
        $display("Response with no access outstanding at cycle %0d", cycle_cnt);
      end
      else if (rsp_valid)
      begin
        // Oldest accepted access owns this response
        exp_rsp = exp_q.pop_front();
        check_value("rsp_o.we", rsp.we, exp_rsp.we);
        check_value("rsp_o.err", rsp.err, exp_rsp.err);
        if (!exp_rsp.we)
          check_value("rsp_o.rdata", rsp.rdata, exp_rsp.rdata);
        rsp_cnt++;
      end
      seen_accept = bus_valid && bus_gnt;
      if (seen_accept)
      begin
        exp_val = predict(req);
        check_value("bus_req_o.addr", bus_req.addr, exp_val.bus.addr);
        check_value("bus_req_o.we", bus_req.we, exp_val.bus.we);
        check_value("bus_req_o.be", bus_req.be, exp_val.bus.be);
        if (req.we)
        begin
          check_value("bus_req_o.wdata", bus_req.wdata, exp_val.bus.wdata);
          for (lane = 0; lane < 4; lane++)
            if (exp_val.bus.be[lane])
              shadow[exp_val.bus.addr[5:2]][8 * lane +: 8] = exp_val.bus.wdata[8 * lane +: 8];
        end
        exp_q.push_back(exp_val.rsp);
        serve_grant();
        acc_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int i;
    for (i = 0; i < 16; i++)
    begin
      // Pattern mixes the full word index into every byte
      mem[i]    = (32'h9E37_79B9 * (i + 1)) ^ {8{i[3:0]}};
      shadow[i] = mem[i];
    end
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    bus_gnt    = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    bus_err    = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    wait (rsp_cnt == NUM_TXN);
    repeat (4) @(posedge clk);
    // Stores applied by the model must match the reference copy
    for (i = 0; i < 16; i++)
      check_value($sformatf("mem[%0d]", i), mem[i], shadow[i]);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("Timeout: only %0d of %0d responses after %0d cycles", rsp_cnt, NUM_TXN,
             cycle_cnt);
    $display("Test failed");
    $finish;
  end

endmodule

// File: list.f
logic/lsu_pkg.sv
logic/lsu_issue.sv
logic/lsu_txn_tracker.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
test/lsu_sva.sv
test/lsu_tb.sv
